// ==== verilog/cache_pkg.sv ====
package cache_pkg;

	// address and data widths, all addresses are word addresses
	localparam int ADDR_W      = 16;
	localparam int WORD_W      = 16;
	localparam int LINE_WORDS  = 4;
	localparam int OFFSET_W    = 2;                    // word select inside a line
	localparam int LINE_W      = WORD_W * LINE_WORDS;
	localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

	// instruction cache, direct mapped, 64 lines
	localparam int I_INDEX_W = 6;                                  // addr bits 7..2
	localparam int I_TAG_W   = ADDR_W - OFFSET_W - I_INDEX_W;      // addr bits 15..8

	// data cache, two ways of 32 sets
	localparam int D_INDEX_W = 5;                                  // addr bits 6..2
	localparam int D_TAG_W   = ADDR_W - OFFSET_W - D_INDEX_W;      // addr bits 15..7

	// main memory
	localparam int MEM_LATENCY = 4;
	localparam int MEM_CREDITS = 1;
	localparam int MEM_LINES   = 2 ** LINE_ADDR_W;
	localparam int CREDIT_W    = $clog2(MEM_CREDITS + 1);
	localparam int LAT_W       = $clog2(MEM_LATENCY);   // holds MEM_LATENCY-1

	// a cache line, seen flat for memory or as words for the caches
	// word 0 sits in bits 15..0
	typedef union packed {
		logic [LINE_W-1:0]                  bits;
		logic [LINE_WORDS-1:0][WORD_W-1:0]  words;
	} line_u;

	// line request toward memory
	typedef struct packed {
		logic                    valid;
		logic                    we;
		logic [LINE_ADDR_W-1:0]  line_addr;
		line_u                   wdata;
	} mem_req_t;

	// memory response, rdata is meaningless for a write
	typedef struct packed {
		logic   valid;
		line_u  rdata;
	} mem_rsp_t;

	// processor data port request
	typedef struct packed {
		logic               valid;
		logic               we;
		logic [ADDR_W-1:0]  addr;
		logic [WORD_W-1:0]  wdata;
	} cpu_req_t;

endpackage

// ==== verilog/icache_dm.sv ====
`timescale 1ns/1ps

module icache_dm (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          i_req,
	input  logic [cache_pkg::ADDR_W-1:0]  i_addr,
	output logic                          o_ready,
	output logic                          o_rvalid,
	output logic [cache_pkg::WORD_W-1:0]  o_instr,
	output cache_pkg::mem_req_t           o_mem_req,
	input  logic                          i_grant,
	input  cache_pkg::mem_rsp_t           i_mem_rsp
);
	import cache_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT} state_t;

	state_t                    state;
	logic [2**I_INDEX_W-1:0]   valid;
	logic [I_TAG_W-1:0]        tags [2**I_INDEX_W];
	line_u                     lines [2**I_INDEX_W];
	logic [ADDR_W-1:0]         miss_addr;   // address of the fetch being refilled
	logic [I_INDEX_W-1:0]      idx;
	logic [I_INDEX_W-1:0]      miss_idx;
	logic                      hit;
	logic                      accept;

	assign idx      = i_addr[OFFSET_W +: I_INDEX_W];
	assign miss_idx = miss_addr[OFFSET_W +: I_INDEX_W];
	assign hit      = valid[idx] && (tags[idx] == i_addr[ADDR_W-1 -: I_TAG_W]);
	assign o_ready  = (state == S_IDLE);
	assign accept   = o_ready && i_req;

	// line read only, held until granted
	assign o_mem_req.valid     = (state == S_REQ);
	assign o_mem_req.we        = 1'b0;
	assign o_mem_req.line_addr = miss_addr[ADDR_W-1:OFFSET_W];
	assign o_mem_req.wdata     = '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= S_IDLE;
			valid    <= '0;
			o_rvalid <= 1'b0;
		end else begin
			o_rvalid <= 1'b0;
			case (state)
				S_IDLE: if (accept) begin
					if (hit)
						o_rvalid <= 1'b1;
					else
						state <= S_REQ;
				end
				S_REQ: if (i_grant) state <= S_WAIT;
				S_WAIT: if (i_mem_rsp.valid) begin
					valid[miss_idx] <= 1'b1;
					o_rvalid        <= 1'b1;   // word goes out with the fill
					state           <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			miss_addr <= i_addr;
			o_instr   <= lines[idx].words[i_addr[OFFSET_W-1:0]];
		end
		if (state == S_WAIT && i_mem_rsp.valid) begin
			tags[miss_idx]  <= miss_addr[ADDR_W-1 -: I_TAG_W];
			lines[miss_idx] <= i_mem_rsp.rdata;
			o_instr         <= i_mem_rsp.rdata.words[miss_addr[OFFSET_W-1:0]];
		end
	end

	// the arbiter hands us a response only while our line read is out
	a_rsp_while_waiting: assert property (@(posedge clk) disable iff (rst)
		i_mem_rsp.valid |-> (state == S_WAIT));

endmodule

// ==== verilog/dcache_2way.sv ====
`timescale 1ns/1ps

module dcache_2way (
	input  logic                          clk,
	input  logic                          rst,
	input  cache_pkg::cpu_req_t           i_req,
	output logic                          o_ready,
	output logic                          o_rvalid,
	output logic [cache_pkg::WORD_W-1:0]  o_rdata,
	output cache_pkg::mem_req_t           o_mem_req,
	input  logic                          i_grant,
	input  cache_pkg::mem_rsp_t           i_mem_rsp
);
	import cache_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_WB_REQ, S_WB_WAIT, S_RD_REQ, S_RD_WAIT} state_t;

	state_t                   state;
	logic [2**D_INDEX_W-1:0]  valid [2];
	logic [2**D_INDEX_W-1:0]  dirty [2];
	logic [2**D_INDEX_W-1:0]  lru;                  // way to replace next
	logic [D_TAG_W-1:0]       tags [2][2**D_INDEX_W];
	line_u                    lines [2][2**D_INDEX_W];
	cpu_req_t                 req_q;                // missed request
	logic                     vict_q;
	logic [D_INDEX_W-1:0]     idx;
	logic [D_INDEX_W-1:0]     q_idx;
	logic [OFFSET_W-1:0]      off;
	logic [OFFSET_W-1:0]      q_off;
	logic [D_TAG_W-1:0]       tag;
	logic [1:0]               hit_way;
	logic                     hit;
	logic                     hit_w;
	logic                     victim;
	logic                     accept;
	line_u                    fill;

	assign idx   = i_req.addr[OFFSET_W +: D_INDEX_W];
	assign off   = i_req.addr[OFFSET_W-1:0];
	assign tag   = i_req.addr[ADDR_W-1 -: D_TAG_W];
	assign q_idx = req_q.addr[OFFSET_W +: D_INDEX_W];
	assign q_off = req_q.addr[OFFSET_W-1:0];

	assign hit_way[0] = valid[0][idx] && (tags[0][idx] == tag);
	assign hit_way[1] = valid[1][idx] && (tags[1][idx] == tag);
	assign hit        = |hit_way;
	assign hit_w      = hit_way[1];

	// an empty way first, way 0 before way 1, then lru
	assign victim  = !valid[0][idx] ? 1'b0 : (!valid[1][idx] ? 1'b1 : lru[idx]);
	assign o_ready = (state == S_IDLE);
	assign accept  = o_ready && i_req.valid;

	// refill line with a pending store merged in
	always_comb begin
		fill = i_mem_rsp.rdata;
		if (req_q.we)
			fill.words[q_off] = req_q.wdata;
	end

	always_comb begin
		o_mem_req = '0;
		if (state == S_WB_REQ) begin
			o_mem_req.valid     = 1'b1;
			o_mem_req.we        = 1'b1;
			o_mem_req.line_addr = {tags[vict_q][q_idx], q_idx};   // old line address
			o_mem_req.wdata     = lines[vict_q][q_idx];
		end else if (state == S_RD_REQ) begin
			o_mem_req.valid     = 1'b1;
			o_mem_req.line_addr = req_q.addr[ADDR_W-1:OFFSET_W];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= S_IDLE;
			valid    <= '{default: '0};
			dirty    <= '{default: '0};
			lru      <= '0;
			o_rvalid <= 1'b0;
		end else begin
			o_rvalid <= 1'b0;
			case (state)
				S_IDLE: if (accept) begin
					if (hit) begin
						o_rvalid   <= 1'b1;
						lru[idx]   <= ~hit_w;
						if (i_req.we)
							dirty[hit_w][idx] <= 1'b1;
					end else if (valid[victim][idx] && dirty[victim][idx]) begin
						state <= S_WB_REQ;
					end else begin
						state <= S_RD_REQ;
					end
				end
				S_WB_REQ:  if (i_grant) state <= S_WB_WAIT;
				S_WB_WAIT: if (i_mem_rsp.valid) state <= S_RD_REQ;   // write acked
				S_RD_REQ:  if (i_grant) state <= S_RD_WAIT;
				S_RD_WAIT: if (i_mem_rsp.valid) begin
					valid[vict_q][q_idx] <= 1'b1;
					dirty[vict_q][q_idx] <= req_q.we;
					lru[q_idx]           <= ~vict_q;
					o_rvalid             <= 1'b1;
					state                <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q   <= i_req;
			vict_q  <= victim;
			o_rdata <= lines[hit_w][idx].words[off];
			if (hit && i_req.we)
				lines[hit_w][idx].words[off] <= i_req.wdata;
		end
		if (state == S_RD_WAIT && i_mem_rsp.valid) begin
			tags[vict_q][q_idx]  <= req_q.addr[ADDR_W-1 -: D_TAG_W];
			lines[vict_q][q_idx] <= fill;
			o_rdata              <= fill.words[q_off];
		end
	end

	// a refill never leaves a second copy of the tag in the set
	a_one_way_hit: assert property (@(posedge clk) disable iff (rst)
		accept |-> !(hit_way[0] && hit_way[1]));

endmodule

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                 clk,
	input  logic                 rst,
	input  cache_pkg::mem_req_t  i_d_req,
	input  cache_pkg::mem_req_t  i_i_req,
	output logic                 o_d_grant,
	output logic                 o_i_grant,
	output cache_pkg::mem_req_t  o_mem_req,
	input  cache_pkg::mem_rsp_t  i_mem_rsp,
	output cache_pkg::mem_rsp_t  o_d_rsp,
	output cache_pkg::mem_rsp_t  o_i_rsp
);
	import cache_pkg::*;

	logic [CREDIT_W-1:0]  credits;
	logic                 owner_d;      // outstanding transaction belongs to the data cache
	logic                 has_credit;

	assign has_credit = (credits != '0);

	// data cache wins a tie
	assign o_d_grant = has_credit && i_d_req.valid;
	assign o_i_grant = has_credit && i_i_req.valid && !i_d_req.valid;

	always_comb begin
		if (o_d_grant)
			o_mem_req = i_d_req;
		else if (o_i_grant)
			o_mem_req = i_i_req;
		else
			o_mem_req = '0;
	end

	// response steered back by owner
	assign o_d_rsp.valid = i_mem_rsp.valid && owner_d;
	assign o_d_rsp.rdata = i_mem_rsp.rdata;
	assign o_i_rsp.valid = i_mem_rsp.valid && !owner_d;
	assign o_i_rsp.rdata = i_mem_rsp.rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CREDIT_W'(MEM_CREDITS);
			owner_d <= 1'b0;
		end else begin
			credits <= credits - CREDIT_W'(o_mem_req.valid) + CREDIT_W'(i_mem_rsp.valid);
			if (o_mem_req.valid)
				owner_d <= o_d_grant;
		end
	end

	// a credit comes back only while one is spent, so the count stays within MEM_CREDITS
	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		i_mem_rsp.valid |-> (credits < CREDIT_W'(MEM_CREDITS)));

endmodule

// ==== verilog/main_mem.sv ====
`timescale 1ns/1ps

module main_mem (
	input  logic                 clk,
	input  logic                 rst,
	input  cache_pkg::mem_req_t  i_req,
	output cache_pkg::mem_rsp_t  o_rsp
);
	import cache_pkg::*;

	logic [LINE_W-1:0]  mem [MEM_LINES];
	mem_req_t           req_q;
	logic [LAT_W-1:0]   count;
	logic               pending;
	logic               fire;        // last cycle of the latency window

	initial begin
		for (int k = 0; k < MEM_LINES; k++)
			mem[k] = '0;
	end

	assign fire = pending && (count == LAT_W'(1));

	always_ff @(posedge clk) begin
		if (rst) begin
			pending     <= 1'b0;
			count       <= '0;
			o_rsp.valid <= 1'b0;
		end else begin
			o_rsp.valid <= fire;   // one cycle pulse, also returns the credit
			if (i_req.valid) begin
				pending <= 1'b1;
				count   <= LAT_W'(MEM_LATENCY - 1);
			end else if (fire) begin
				pending <= 1'b0;
			end else if (pending) begin
				count <= count - LAT_W'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_req.valid)
			req_q <= i_req;
		if (fire && req_q.we)
			mem[req_q.line_addr] <= req_q.wdata.bits;
		if (fire && !req_q.we)
			o_rsp.rdata.bits <= mem[req_q.line_addr];
	end

	a_one_pending: assert property (@(posedge clk) disable iff (rst)
		i_req.valid |-> !pending);

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          i_i_req,
	input  logic [cache_pkg::ADDR_W-1:0]  i_i_addr,
	output logic                          o_i_ready,
	output logic                          o_i_rvalid,
	output logic [cache_pkg::WORD_W-1:0]  o_instr,
	input  cache_pkg::cpu_req_t           i_d_req,
	output logic                          o_d_ready,
	output logic                          o_d_rvalid,
	output logic [cache_pkg::WORD_W-1:0]  o_d_rdata
);
	import cache_pkg::*;

	mem_req_t  i_mem_req;
	mem_req_t  d_mem_req;
	mem_req_t  mem_req;      // arbiter to memory
	mem_rsp_t  mem_rsp;
	mem_rsp_t  i_rsp;
	mem_rsp_t  d_rsp;
	logic      i_grant;
	logic      d_grant;

	icache_dm u_icache (
		.clk(clk), .rst(rst), .i_req(i_i_req), .i_addr(i_i_addr),
		.o_ready(o_i_ready), .o_rvalid(o_i_rvalid), .o_instr(o_instr),
		.o_mem_req(i_mem_req), .i_grant(i_grant), .i_mem_rsp(i_rsp)
	);

	dcache_2way u_dcache (
		.clk(clk), .rst(rst), .i_req(i_d_req),
		.o_ready(o_d_ready), .o_rvalid(o_d_rvalid), .o_rdata(o_d_rdata),
		.o_mem_req(d_mem_req), .i_grant(d_grant), .i_mem_rsp(d_rsp)
	);

	mem_arbiter u_arbiter (
		.clk(clk), .rst(rst), .i_d_req(d_mem_req), .i_i_req(i_mem_req),
		.o_d_grant(d_grant), .o_i_grant(i_grant), .o_mem_req(mem_req),
		.i_mem_rsp(mem_rsp), .o_d_rsp(d_rsp), .o_i_rsp(i_rsp)
	);

	main_mem u_mem (.clk(clk), .rst(rst), .i_req(mem_req), .o_rsp(mem_rsp));

endmodule

// ==== verification/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;
	import cache_pkg::*;

	localparam int WAIT_LIMIT = 100;   // cycles, well above a writeback plus a refill

	logic               clk = 1'b0;
	logic               rst;
	logic               i_i_req;
	logic [ADDR_W-1:0]  i_i_addr;
	logic               o_i_ready;
	logic               o_i_rvalid;
	logic [WORD_W-1:0]  o_instr;
	cpu_req_t           i_d_req;
	logic               o_d_ready;
	logic               o_d_rvalid;
	logic [WORD_W-1:0]  o_d_rdata;

	logic [WORD_W-1:0]  ref_mem [2**ADDR_W];   // word image of every accepted data write

	cache_top DUT (
		.clk(clk), .rst(rst), .i_i_req(i_i_req), .i_i_addr(i_i_addr),
		.o_i_ready(o_i_ready), .o_i_rvalid(o_i_rvalid), .o_instr(o_instr),
		.i_d_req(i_d_req), .o_d_ready(o_d_ready), .o_d_rvalid(o_d_rvalid),
		.o_d_rdata(o_d_rdata)
	);

	always #50 clk = ~clk;

	task automatic stop_on_error();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic report_hang(input string what);
		$display("timeout: %s", what);
		stop_on_error();
	endtask

	task automatic expect_word(input string name, input logic [WORD_W-1:0] exp,
		input logic [WORD_W-1:0] got);
		assert (got === exp) else begin
			$display("mismatch %s expected %h actual %h", name, exp, got);
			stop_on_error();
		end
	endtask

	task automatic expect_latency(input string name, input int exp, input int got);
		assert (got == exp) else begin
			$display("mismatch %s latency expected %0d actual %0d", name, exp, got);
			stop_on_error();
		end
	endtask

	task automatic expect_miss(input string name, input int lat);
		assert (lat > 1) else begin
			$display("%s answered one cycle after acceptance although a miss was due", name);
			stop_on_error();
		end
	endtask

	// word address from data cache fields: tag 15..7, set 6..2, word 1..0
	function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set_idx,
		input int word);
		return ADDR_W'((tag << (D_INDEX_W + OFFSET_W)) | (set_idx << OFFSET_W) | word);
	endfunction

	task automatic data_op(input logic we, input logic [ADDR_W-1:0] addr,
		input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata, output int lat);
		cpu_req_t  req;
		int        t;
		req.valid = 1'b1;
		req.we    = we;
		req.addr  = addr;
		req.wdata = wdata;
		@(posedge clk);
		i_d_req <= req;
		t = 0;
		@(negedge clk);
		while (!o_d_ready) begin
			t++;
			if (t > WAIT_LIMIT)
				report_hang("data port never became ready");
			@(negedge clk);
		end
		@(posedge clk);
		i_d_req <= '0;   // accepted on this edge
		if (we)
			ref_mem[addr] = wdata;
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
			if (lat > WAIT_LIMIT)
				report_hang("data port never answered");
		end while (!o_d_rvalid);
		assert (o_d_ready) else begin
			$display("data port ready stayed low with rvalid high");
			stop_on_error();
		end
		rdata = o_d_rdata;
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
		logic [WORD_W-1:0]  ack_data;   // undefined for a write
		int                 lat;
		data_op(1'b1, addr, data, ack_data, lat);
	endtask

	task automatic read_check(input string name, input logic [ADDR_W-1:0] addr,
		output int lat);
		logic [WORD_W-1:0]  got;
		data_op(1'b0, addr, 16'h0, got, lat);
		expect_word(name, ref_mem[addr], got);
	endtask

	task automatic fetch_check(input string name, input logic [ADDR_W-1:0] addr,
		output int lat);
		int  t;
		@(posedge clk);
		i_i_req  <= 1'b1;
		i_i_addr <= addr;
		t = 0;
		@(negedge clk);
		while (!o_i_ready) begin
			t++;
			if (t > WAIT_LIMIT)
				report_hang("instruction port never became ready");
			@(negedge clk);
		end
		@(posedge clk);
		i_i_req <= 1'b0;
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
			if (lat > WAIT_LIMIT)
				report_hang("instruction port never answered");
		end while (!o_i_rvalid);
		assert (o_i_ready) else begin
			$display("instruction port ready stayed low with rvalid high");
			stop_on_error();
		end
		expect_word(name, ref_mem[addr], o_instr);
	endtask

	initial begin
		int                 lat;
		int                 ilat;
		int                 kind;
		logic [ADDR_W-1:0]  a;
		void'($urandom(32'h669b));
		for (int k = 0; k < 2**ADDR_W; k++)
			ref_mem[k] = '0;
		rst      = 1'b1;
		i_i_req  = 1'b0;
		i_i_addr = '0;
		i_d_req  = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (o_i_ready && o_d_ready && !o_i_rvalid && !o_d_rvalid) else begin
			$display("ready or rvalid outputs wrong after reset");
			stop_on_error();
		end

		// write allocates, so the read back is a hit
		a = make_addr(1, 1, 2);
		write_word(a, 16'($urandom));
		read_check("write_read", a, lat);
		expect_latency("write_read", 1, lat);

		// three tags in set 2, the third pushes out the dirty lru way
		for (int t = 1; t <= 3; t++)
			write_word(make_addr(t, 2, t), 16'($urandom));
		for (int t = 1; t <= 3; t++) begin
			read_check("evict_dirty", make_addr(t, 2, t), lat);
			if (t == 1)
				expect_miss("evict_dirty", lat);
		end

		// code lines: tags 4 and 5 of sets 8..11, then pushed out by tags 6 and 7
		for (int t = 4; t <= 5; t++)
			for (int s = 8; s <= 11; s++)
				for (int w = 0; w < LINE_WORDS; w++)
					write_word(make_addr(t, s, w), 16'($urandom));
		for (int t = 6; t <= 7; t++)
			for (int s = 8; s <= 11; s++)
				write_word(make_addr(t, s, 0), 16'($urandom));
		fetch_check("ifetch_miss", make_addr(4, 10, 1), lat);
		expect_miss("ifetch_miss", lat);
		fetch_check("ifetch_hit", make_addr(4, 10, 3), lat);
		expect_latency("ifetch_hit", 1, lat);

		// both ports miss on the same edge
		fork
			read_check("parallel_data", make_addr(4, 8, 0), lat);
			fetch_check("parallel_instr", make_addr(5, 9, 2), ilat);
		join
		expect_miss("parallel_data", lat);
		expect_miss("parallel_instr", ilat);

		// random mix, data in sets 0..3, fetches only from the code lines
		for (int n = 0; n < 200; n++) begin
			kind = int'($urandom % 3);
			if (kind == 2) begin
				a = make_addr(4 + int'($urandom % 2), 8 + int'($urandom % 4),
					int'($urandom % 4));
				fetch_check("random_ifetch", a, lat);
			end else begin
				a = make_addr(int'($urandom % 4), int'($urandom % 4), int'($urandom % 4));
				if (kind == 1)
					write_word(a, 16'($urandom));
				else
					read_check("random_data", a, lat);
			end
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== tb.f ====
verilog/cache_pkg.sv
verilog/icache_dm.sv
verilog/dcache_2way.sv
verilog/mem_arbiter.sv
verilog/main_mem.sv
verilog/cache_top.sv
verification/cache_tb.sv

// ==== Makefile ====
SRCS := $(filter %.sv %.v,$(shell cat tb.f))

all: run

obj_dir/Vcache_tb: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module cache_tb -f tb.f

run: obj_dir/Vcache_tb
	./obj_dir/Vcache_tb | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
